//--- hw/tetris_pkg.sv
package tetris_pkg;

    // Playfield size
    localparam int FIELD_ROWS = 20;
    localparam int FIELD_COLS = 10;

    // Push buttons
    localparam int NUM_KEYS   = 20;
    localparam int KEY_CODE_W = 5;

    localparam logic [KEY_CODE_W-1:0] KEY_LEFT  = 5'd8;  // Shift piece one column left
    localparam logic [KEY_CODE_W-1:0] KEY_RIGHT = 5'd9;  // Shift piece one column right

    // Row 0 on top, bit FIELD_COLS-1 is the leftmost column
    typedef logic [FIELD_ROWS-1:0][FIELD_COLS-1:0] field_t;

    // Spawn order follows the encoding
    typedef enum logic [2:0] {
        PIECE_I = 3'd0,
        PIECE_O = 3'd1,
        PIECE_L = 3'd2,
        PIECE_J = 3'd3,
        PIECE_S = 3'd4,
        PIECE_Z = 3'd5,
        PIECE_T = 3'd6
    } piece_t;

endpackage

//--- hw/key_sync.sv
`timescale 1ns/100ps

module key_sync (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [tetris_pkg::NUM_KEYS-1:0]     pb,
    output logic                                key_strobe,
    output logic [tetris_pkg::KEY_CODE_W-1:0]   key_code
);
    import tetris_pkg::*;

    logic [NUM_KEYS-1:0]   sync_meta;   // First synchronizer stage
    logic [NUM_KEYS-1:0]   sync_q;      // Second stage, safe to use
    logic [NUM_KEYS-1:0]   sync_prev;   // Last cycle's level for edge detect
    logic [NUM_KEYS-1:0]   rising;
    logic [KEY_CODE_W-1:0] enc_code;

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            sync_meta <= '0;
            sync_q    <= '0;
            sync_prev <= '0;
        end else begin
            sync_meta <= pb;
            sync_q    <= sync_meta;
            sync_prev <= sync_q;
        end
    end

    assign rising = sync_q & ~sync_prev;

    // Walk down so the lowest button overwrites the others
    always_comb begin
        enc_code = '0;
        for (int i = NUM_KEYS - 1; i >= 0; i--) begin
            if (rising[i])
                enc_code = KEY_CODE_W'(i);
        end
    end

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            key_strobe <= 1'b0;
            key_code   <= '0;
        end else begin
            key_strobe <= |rising;    // One cycle per new press
            key_code   <= enc_code;
        end
    end

endmodule

//--- hw/piece_gen.sv
`timescale 1ns/100ps

module piece_gen #(
    parameter int SPAWN_COL = 3
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                spawn,
    output tetris_pkg::piece_t  piece_type,
    output tetris_pkg::field_t  spawn_mask
);
    import tetris_pkg::*;

    logic [3:0] shape_top;   // Row 0 pattern, bit 3 leftmost
    logic [3:0] shape_bot;   // Row 1 pattern

    // Type counter, wraps after T
    always_ff @(posedge clk, posedge reset) begin
        if (reset)
            piece_type <= PIECE_I;
        else if (spawn) begin
            if (piece_type == PIECE_T)
                piece_type <= PIECE_I;
            else
                piece_type <= piece_t'(piece_type + 3'd1);
        end
    end

    // Shape table, all shapes start in pattern column 3
    always_comb begin
        case (piece_type)
            PIECE_I: begin
                shape_top = 4'b1111;
                shape_bot = 4'b0000;
            end
            PIECE_O: begin
                shape_top = 4'b1100;
                shape_bot = 4'b1100;
            end
            PIECE_L: begin
                shape_top = 4'b1110;
                shape_bot = 4'b1000;
            end
            PIECE_J: begin
                shape_top = 4'b1110;
                shape_bot = 4'b0010;
            end
            PIECE_S: begin
                shape_top = 4'b0110;
                shape_bot = 4'b1100;
            end
            PIECE_Z: begin
                shape_top = 4'b1100;
                shape_bot = 4'b0110;
            end
            PIECE_T: begin
                shape_top = 4'b1110;
                shape_bot = 4'b0100;
            end
            default: begin
                shape_top = 4'b0000;
                shape_bot = 4'b0000;
            end
        endcase
    end

    // Place pattern at the left wall, then move SPAWN_COL columns right
    always_comb begin
        spawn_mask    = '0;
        spawn_mask[0] = {shape_top, {(FIELD_COLS - 4){1'b0}}} >> SPAWN_COL;
        spawn_mask[1] = {shape_bot, {(FIELD_COLS - 4){1'b0}}} >> SPAWN_COL;
    end

    a_type_range: assert property (@(posedge clk) disable iff (reset)
        piece_type inside {[PIECE_I:PIECE_T]})
        else $error("piece_type out of range");

endmodule

//--- hw/piece_mover.sv
`timescale 1ns/100ps

module piece_mover (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                spawn,
    input  logic                                falling,
    input  logic                                merge,
    input  logic                                drop_tick,
    input  logic                                key_strobe,
    input  logic [tetris_pkg::KEY_CODE_W-1:0]   key_code,
    input  tetris_pkg::field_t                  spawn_mask,
    input  tetris_pkg::field_t                  stored,
    output tetris_pkg::field_t                  piece_mask,
    output logic                                landed
);
    import tetris_pkg::*;

    field_t down_mask;
    field_t left_mask;
    field_t right_mask;
    logic   down_blocked;
    logic   left_blocked;
    logic   right_blocked;
    logic   left_hit_wall;
    logic   right_hit_wall;
    logic   key_left;
    logic   key_right;

    // Candidate positions one step away
    always_comb begin
        down_mask      = '0;
        left_hit_wall  = 1'b0;
        right_hit_wall = 1'b0;
        for (int r = 0; r < FIELD_ROWS; r++) begin
            if (r > 0)
                down_mask[r] = piece_mask[r-1];
            left_mask[r]   = piece_mask[r] << 1;
            right_mask[r]  = piece_mask[r] >> 1;
            left_hit_wall  = left_hit_wall | piece_mask[r][FIELD_COLS-1];
            right_hit_wall = right_hit_wall | piece_mask[r][0];
        end
    end

    // Floor, walls and the stack all block
    assign down_blocked  = (|piece_mask[FIELD_ROWS-1]) | (|(down_mask & stored));
    assign left_blocked  = left_hit_wall | (|(left_mask & stored));
    assign right_blocked = right_hit_wall | (|(right_mask & stored));

    assign key_left  = key_strobe && (key_code == KEY_LEFT);
    assign key_right = key_strobe && (key_code == KEY_RIGHT);

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            piece_mask <= '0;
        end else if (spawn) begin
            piece_mask <= spawn_mask;
        end else if (merge || !falling) begin
            piece_mask <= '0;           // Also empties on game over
        end else if (drop_tick) begin   // Tick beats a key in the same cycle
            if (!down_blocked)
                piece_mask <= down_mask;
        end else if (key_left && !left_blocked) begin
            piece_mask <= left_mask;
        end else if (key_right && !right_blocked) begin
            piece_mask <= right_mask;
        end
    end

    // Single pulse per landing, repeat ticks are ignored
    always_ff @(posedge clk, posedge reset) begin
        if (reset)
            landed <= 1'b0;
        else
            landed <= falling && drop_tick && down_blocked && !landed;
    end

    a_no_overlap: assert property (@(posedge clk) disable iff (reset)
        falling |-> !(|(piece_mask & stored)))
        else $error("Falling piece overlaps stored blocks");

    a_landed_in_fall: assert property (@(posedge clk) disable iff (reset)
        landed |-> falling)
        else $error("landed outside falling");

endmodule

//--- hw/playfield.sv
`timescale 1ns/100ps

module playfield (
    input  logic                clk,
    input  logic                reset,
    input  logic                merge,
    input  logic                clear,
    input  tetris_pkg::field_t  piece_mask,
    input  tetris_pkg::field_t  spawn_mask,
    output tetris_pkg::field_t  stored,
    output logic                overlap
);
    import tetris_pkg::*;

    // Permanent blocks
    always_ff @(posedge clk, posedge reset) begin
        if (reset)
            stored <= '0;
        else if (clear)
            stored <= '0;               // New game
        else if (merge)
            stored <= stored | piece_mask;
    end

    // New piece would land on the stack
    assign overlap = |(spawn_mask & stored);

    a_merge_clear: assert property (@(posedge clk) disable iff (reset)
        !(merge && clear))
        else $error("merge and clear together");

endmodule

//--- hw/game_ctrl.sv
`timescale 1ns/100ps

module game_ctrl (
    input  logic clk,
    input  logic reset,
    input  logic new_game,
    input  logic landed,
    input  logic overlap,
    output logic spawn,
    output logic falling,
    output logic merge,
    output logic clear,
    output logic game_over
);

    typedef enum logic [2:0] {
        IDLE,       // Held in reset, leaves on the first edge
        SPAWN,
        FALLING,
        MERGE,
        GAMEOVER,
        CLEAR
    } state_t;

    state_t state, next_state;

    always_ff @(posedge clk, posedge reset) begin
        if (reset)
            state <= IDLE;
        else
            state <= next_state;
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE:     next_state = SPAWN;
            SPAWN:    next_state = overlap ? GAMEOVER : FALLING;  // Spawn on the stack ends it
            FALLING:  next_state = landed ? MERGE : FALLING;
            MERGE:    next_state = SPAWN;
            GAMEOVER: next_state = new_game ? CLEAR : GAMEOVER;
            CLEAR:    next_state = SPAWN;
            default:  next_state = IDLE;
        endcase
    end

    // Moore outputs
    assign spawn     = (state == SPAWN);
    assign falling   = (state == FALLING);
    assign merge     = (state == MERGE);
    assign clear     = (state == CLEAR);
    assign game_over = (state == GAMEOVER);

    a_spawn_single: assert property (@(posedge clk) disable iff (reset)
        spawn |=> !spawn)
        else $error("spawn held two cycles");

endmodule

//--- hw/tetris_top.sv
`timescale 1ns/100ps

module tetris_top #(
    parameter int SPAWN_COL = 3
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [tetris_pkg::NUM_KEYS-1:0] pb,
    input  logic                            drop_tick,
    input  logic                            new_game,
    output tetris_pkg::field_t              display,
    output tetris_pkg::piece_t              piece_type,
    output logic                            spawn,
    output logic                            game_over
);
    import tetris_pkg::*;

    logic                  key_strobe;
    logic [KEY_CODE_W-1:0] key_code;
    logic                  falling;
    logic                  merge;
    logic                  clear;
    logic                  landed;
    logic                  overlap;
    field_t                spawn_mask;
    field_t                piece_mask;
    field_t                stored;

    key_sync u_key_sync (
        .clk        (clk),
        .reset      (reset),
        .pb         (pb),
        .key_strobe (key_strobe),
        .key_code   (key_code)
    );

    piece_gen #(
        .SPAWN_COL  (SPAWN_COL)
    ) u_piece_gen (
        .clk        (clk),
        .reset      (reset),
        .spawn      (spawn),
        .piece_type (piece_type),
        .spawn_mask (spawn_mask)
    );

    piece_mover u_piece_mover (
        .clk        (clk),
        .reset      (reset),
        .spawn      (spawn),
        .falling    (falling),
        .merge      (merge),
        .drop_tick  (drop_tick),
        .key_strobe (key_strobe),
        .key_code   (key_code),
        .spawn_mask (spawn_mask),
        .stored     (stored),
        .piece_mask (piece_mask),
        .landed     (landed)
    );

    playfield u_playfield (
        .clk        (clk),
        .reset      (reset),
        .merge      (merge),
        .clear      (clear),
        .piece_mask (piece_mask),
        .spawn_mask (spawn_mask),
        .stored     (stored),
        .overlap    (overlap)
    );

    game_ctrl u_game_ctrl (
        .clk        (clk),
        .reset      (reset),
        .new_game   (new_game),
        .landed     (landed),
        .overlap    (overlap),
        .spawn      (spawn),
        .falling    (falling),
        .merge      (merge),
        .clear      (clear),
        .game_over  (game_over)
    );

    // Stack plus active piece
    assign display = stored | piece_mask;

endmodule

//--- bench/tetris_tb.sv
`timescale 1ns/100ps

module tetris_tb;
    import tetris_pkg::*;

    localparam string GOLDEN_FILE = "bench/tetris_golden.txt";
    localparam int    LINE_BITS   = 8 * 96;

    logic                clk;
    logic                reset;
    logic [NUM_KEYS-1:0] pb;
    logic                drop_tick;
    logic                new_game;
    field_t              display;
    piece_t              piece_type;
    logic                spawn;
    logic                game_over;

    logic [LINE_BITS-1:0] lines[$];     // Whole golden file
    logic [8*24-1:0]      test_name;
    int cycle_limit = 0;
    int cycles      = 0;
    int check_count = 0;
    int error_count = 0;
    int test_count  = 0;
    int test_checks = 0;
    int test_errors = 0;

    tetris_top #(
        .SPAWN_COL  (3)
    ) dut (
        .clk        (clk),
        .reset      (reset),
        .pb         (pb),
        .drop_tick  (drop_tick),
        .new_game   (new_game),
        .display    (display),
        .piece_type (piece_type),
        .spawn      (spawn),
        .game_over  (game_over)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Quiet gap after each command
    task automatic settle();
        repeat (6) @(posedge clk);
    endtask

    task automatic pulse_ticks(input int count);
        repeat (count) begin
            @(posedge clk);
            drop_tick <= 1'b1;
            @(posedge clk);
            drop_tick <= 1'b0;      // One cycle low between ticks
        end
    endtask

    task automatic press_key(input int key, input int count);
        repeat (count) begin
            @(posedge clk);
            pb[key] <= 1'b1;
            repeat (2) @(posedge clk);
            pb[key] <= 1'b0;
            repeat (2) @(posedge clk);
        end
    endtask

    task automatic wait_spawn();
        @(negedge clk);
        while (!spawn)
            @(negedge clk);
        @(negedge clk);
        check_value("spawn", {9'b0, spawn}, 10'd0);    // Strobe lasts one cycle
    endtask

    task automatic check_value(input string name, input logic [9:0] got,
                               input logic [9:0] exp);
        check_count++;
        test_checks++;
        assert (got === exp)
        else begin
            $display("Fail at %0t ns: %s got %h expected %h", $time, name, got, exp);
            error_count++;
            test_errors++;
        end
    endtask

    // Result line of the test that just ended
    task automatic finish_test();
        if (test_count > 0) begin
            if (test_errors == 0)
                $display("test %0s: ok, %0d checks", test_name, test_checks);
            else
                $display("test %0s: %0d of %0d checks wrong", test_name, test_errors,
                         test_checks);
        end
    endtask

    task automatic run_line(input logic [LINE_BITS-1:0] line);
        logic [8*16-1:0] cmd;
        logic [8*24-1:0] what;
        int              count;
        int              index;
        logic [9:0]      value;
        int              n;
        n = $sscanf(line, "%s", cmd);
        if (n < 1 || cmd == "#")
            return;                     // Blank or comment
        count = 1;
        if (cmd == "test") begin
            n = $sscanf(line, "%s %s", cmd, what);
            finish_test();
            test_name   = what;
            test_count++;
            test_checks = 0;
            test_errors = 0;
        end else if (cmd == "wait") begin
            wait_spawn();
            settle();
        end else if (cmd == "tick") begin
            n = $sscanf(line, "%s %d", cmd, count);
            pulse_ticks(count);
            settle();
        end else if (cmd == "left" || cmd == "right") begin
            n = $sscanf(line, "%s %d", cmd, count);
            press_key((cmd == "left") ? int'(KEY_LEFT) : int'(KEY_RIGHT), count);
            settle();
        end else if (cmd == "newgame") begin
            @(posedge clk);
            new_game <= 1'b1;
            @(posedge clk);
            new_game <= 1'b0;
            settle();
        end else if (cmd == "check") begin
            n = $sscanf(line, "%s %s %d %h", cmd, what, index, value);
            @(negedge clk);             // Sample away from the driving edge
            if (what == "row" && index >= 0 && index < FIELD_ROWS)
                check_value($sformatf("display[%0d]", index), display[index], value);
            else if (what == "game_over")
                check_value("game_over", {9'b0, game_over}, value);
            else if (what == "piece_type")
                check_value("piece_type", {7'b0, 3'(piece_type)}, value);
            else begin
                $display("Golden check names an unknown signal or row: %0s", what);
                error_count++;
                test_errors++;
            end
            settle();
        end else begin
            $display("Golden file holds an unknown command: %0s", cmd);
            error_count++;
            test_errors++;
        end
    endtask

    // Limit grows with the golden file
    initial begin
        wait (cycle_limit > 0);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d cycles", cycle_limit);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        int                   fd;
        logic [LINE_BITS-1:0] line;
        reset     = 1'b1;
        pb        = '0;
        drop_tick = 1'b0;
        new_game  = 1'b0;
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            $display("Could not open golden file %s", GOLDEN_FILE);
            error_count++;
        end else begin
            while (!$feof(fd)) begin
                line = '0;
                if ($fgets(line, fd) != 0)
                    lines.push_back(line);
            end
            $fclose(fd);
        end
        cycle_limit = lines.size() * 40 + 100;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        foreach (lines[i])
            run_line(lines[i]);
        finish_test();
        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
        if (error_count == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

//--- project.f
hw/tetris_pkg.sv
hw/key_sync.sv
hw/piece_gen.sv
hw/piece_mover.sv
hw/playfield.sv
hw/game_ctrl.sv
hw/tetris_top.sv
bench/tetris_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tetris_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= project.f
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@$(BIN) | tee /dev/stderr | grep -q "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- bench/tetris_golden.txt
# command [count]: tick, left and right take a count, wait and newgame take none
# check <row|game_over|piece_type> <row index, else 0> <expected hex, bit 9 is column 0>
test spawn
wait
check row 0 078
check row 1 000
check piece_type 0 1
test gravity
tick 3
check row 0 000
check row 2 000
check row 3 078
test side_moves
left 4
check row 3 3c0
right 10
check row 3 00f
test landing
tick 17
check row 18 000
check row 19 00f
check row 0 060
check row 1 060
check piece_type 0 2
test stacking
tick 19
check row 18 060
check row 19 06f
check row 0 070
check row 1 040
tick 17
check row 16 070
check row 17 040
test game_over
tick 15
tick 13
tick 11
tick 9
tick 8
tick 6
tick 4
tick 2
check game_over 0 1
check row 0 000
check row 1 070
check row 2 010
test new_game
newgame
check game_over 0 0
check row 0 060
check row 1 030
check row 10 000
check row 19 000
check piece_type 0 6
